/* list.f */
+incdir+.
lpif_link_pkg.sv
lpif_sync_if.sv
lpif_auto_sync.sv
lpif_flit_codec.sv
lpif_phy_mapper.sv
lpif_link_top.sv
lpif_link_chk.sv
lpif_link_tb.sv

/* lpif_auto_sync.sv */
//////////////////////////////////////////////////////////////////////
// Online release delays, marker hold and strobe generation
// Feeds the codec and PHY mapper through lpif_sync_if
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lpif_link_params.svh"

module lpif_auto_sync (
  input  logic                      clk_wr,
  input  logic                      rst_wr_n,

  // Raw online requests
  input  logic                      tx_online,
  input  logic                      rx_online,

  // Release delays and strobe period
  input  logic [`LPIF_DLY_W-1:0]    delay_x_value,
  input  logic [`LPIF_DLY_W-1:0]    delay_y_value,
  input  logic [`LPIF_DLY_W-1:0]    delay_z_value,

  // User bits
  input  lpif_link_pkg::lpif_mrk_t  tx_mrk_userbit,
  input  logic                      tx_stb_userbit,

  lpif_sync_if.src                  sync
);
  import lpif_link_pkg::*;

  // Saturating delay counters
  logic [`LPIF_DLY_W-1:0] tx_cnt;
  logic [`LPIF_DLY_W-1:0] rx_cnt;
  // Words since the last strobe slot
  logic [`LPIF_DLY_W-1:0] stb_cnt;

  logic                   tx_dly_nxt;
  logic                   rx_dly_nxt;
  logic                   tx_dly_q;
  logic                   rx_dly_q;
  lpif_mrk_t              mrk_q;
  logic                   stb_q;
  logic                   stb_wrap;

  // Hold at all ones rather than wrap
  function automatic logic [`LPIF_DLY_W-1:0] sat_inc(input logic [`LPIF_DLY_W-1:0] v);
    sat_inc = (v == '1) ? v : v + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Online delays

  // Counter equals cycles since online was first sampled high
  assign tx_dly_nxt = tx_online && (tx_cnt >= delay_x_value);
  assign rx_dly_nxt = rx_online && (rx_cnt >= delay_y_value);

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_cnt   <= '0;
      rx_cnt   <= '0;
      tx_dly_q <= 1'b0;
      rx_dly_q <= 1'b0;
    end else begin
      // Dropping online restarts the count
      tx_cnt   <= tx_online ? sat_inc(tx_cnt) : '0;
      rx_cnt   <= rx_online ? sat_inc(rx_cnt) : '0;
      tx_dly_q <= tx_dly_nxt;
      rx_dly_q <= rx_dly_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Marker and strobe

  // Period of 0 or 1 puts a strobe on every word
  assign stb_wrap = (delay_z_value <= 1) || (stb_cnt >= delay_z_value - 1'b1);

  // Both track the next flag value so they line up with the first online word
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      mrk_q   <= '0;
      stb_q   <= 1'b0;
      stb_cnt <= '0;
    end else if (!tx_dly_nxt) begin
      mrk_q   <= '0;
      stb_q   <= 1'b0;
      stb_cnt <= '0;
    end else begin
      mrk_q   <= tx_mrk_userbit;
      // Slot 0 of each period, gated by the user enable
      stb_q   <= tx_stb_userbit && (stb_cnt == '0);
      stb_cnt <= stb_wrap ? '0 : stb_cnt + 1'b1;
    end
  end

  assign sync.tx_online_dly = tx_dly_q;
  assign sync.rx_online_dly = rx_dly_q;
  assign sync.mrk_userbit   = mrk_q;
  assign sync.stb_userbit   = stb_q;

endmodule

`default_nettype wire

/* lpif_flit_codec.sv */
//////////////////////////////////////////////////////////////////////
// User-side flit codec with sent and received flit counters
// Packs ustrm fields into tx_flit, unpacks rx_flit onto dstrm
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lpif_link_params.svh"

module lpif_flit_codec (
  input  logic                       clk_wr,
  input  logic                       rst_wr_n,

  // Upstream user fields
  input  logic [`LPIF_STATE_W-1:0]   ustrm_state,
  input  logic [`LPIF_PROTID_W-1:0]  ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0]    ustrm_data,
  input  logic                       ustrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]     ustrm_crc,
  input  logic                       ustrm_crc_valid,
  input  logic                       ustrm_valid,

  // Downstream user fields
  output logic [`LPIF_STATE_W-1:0]   dstrm_state,
  output logic [`LPIF_PROTID_W-1:0]  dstrm_protid,
  output logic [`LPIF_DATA_W-1:0]    dstrm_data,
  output logic                       dstrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]     dstrm_crc,
  output logic                       dstrm_crc_valid,
  output logic                       dstrm_valid,

  // Flits to and from the PHY mapper
  output lpif_link_pkg::lpif_flit_t  tx_flit,
  input  lpif_link_pkg::lpif_flit_t  rx_flit,

  // Flit counters for the debug words
  output logic [15:0]                tx_count,
  output logic [15:0]                rx_count,

  lpif_sync_if.codec                 sync
);
  import lpif_link_pkg::*;

  lpif_flit_t ustrm_flit;
  lpif_flit_t dstrm_q;

  //////////////////////////////////////////////////////////////////////
  // Transmit

  always_comb begin
    ustrm_flit.valid     = ustrm_valid;
    ustrm_flit.crc_valid = ustrm_crc_valid;
    ustrm_flit.crc       = ustrm_crc;
    ustrm_flit.dvalid    = ustrm_dvalid;
    ustrm_flit.data      = ustrm_data;
    ustrm_flit.protid    = ustrm_protid;
    ustrm_flit.state     = ustrm_state;
  end

  // No back-pressure, a flit every clock
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_flit  <= '0;
      tx_count <= '0;
    end else begin
      tx_flit <= ustrm_flit;
      // Mapper loads this flit into tx_phy on the same edge
      if (sync.tx_online_dly && tx_flit.valid) begin
        tx_count <= tx_count + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      dstrm_q  <= '0;
      rx_count <= '0;
    end else if (!sync.rx_online_dly) begin
      // Offline, keep dstrm quiet
      dstrm_q  <= '0;
    end else begin
      dstrm_q <= rx_flit;
      if (rx_flit.valid) begin
        rx_count <= rx_count + 1'b1;
      end
    end
  end

  assign dstrm_state     = dstrm_q.state;
  assign dstrm_protid    = dstrm_q.protid;
  assign dstrm_data      = dstrm_q.data;
  assign dstrm_dvalid    = dstrm_q.dvalid;
  assign dstrm_crc       = dstrm_q.crc;
  assign dstrm_crc_valid = dstrm_q.crc_valid;
  assign dstrm_valid     = dstrm_q.valid;

endmodule

`default_nettype wire

/* lpif_link_chk.sv */
//////////////////////////////////////////////////////////////////////
// Assertions bound into the link top level
// Reset clears outputs, idle PHY word and quiet dstrm while offline
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lpif_link_params.svh"

module lpif_link_chk (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  logic [`LPIF_PHY_W-1:0]     tx_phy,
  input  logic [`LPIF_STATE_W-1:0]   dstrm_state,
  input  logic [`LPIF_PROTID_W-1:0]  dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0]    dstrm_data,
  input  logic                       dstrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]     dstrm_crc,
  input  logic                       dstrm_crc_valid,
  input  logic                       dstrm_valid
);

  logic dstrm_quiet;
  // Number of failed assertions so far
  int unsigned assert_fails = 0;

  assign dstrm_quiet = (dstrm_state == '0) && (dstrm_protid == '0) && (dstrm_data == '0) &&
                       !dstrm_dvalid && (dstrm_crc == '0) && !dstrm_crc_valid && !dstrm_valid;

  // Reset holds the PHY word and dstrm at zero
  a_reset_clear: assert property (@(posedge clk_wr) !rst_n |-> (tx_phy == '0) && dstrm_quiet)
    else begin
      assert_fails++;
      $error("tx_phy or dstrm not cleared during reset");
    end

  // Flag falls one clock after the drop, tx_phy one clock later
  a_tx_idle: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (!tx_online) [*3] |-> (tx_phy == '0))
    else begin
      assert_fails++;
      $error("tx_phy carries data while tx_online is low");
    end

  // Receive side has one more register stage
  a_rx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (!rx_online) [*3] |-> dstrm_quiet)
    else begin
      assert_fails++;
      $error("dstrm outputs active while rx_online is low");
    end

endmodule

bind lpif_link_top lpif_link_chk lpif_link_chk_inst (.*);

`default_nettype wire

/* lpif_link_params.svh */
//////////////////////////////////////////////////////////////////////
// Width macros for the die-to-die link-layer slave
// Include wherever a flit field, PHY word or delay width is needed
//////////////////////////////////////////////////////////////////////

`ifndef LPIF_LINK_PARAMS_SVH
`define LPIF_LINK_PARAMS_SVH

// User data bus
`define LPIF_DATA_W    64

// Flit header fields
`define LPIF_STATE_W   4
`define LPIF_PROTID_W  4

// CRC field, carried but not generated here
`define LPIF_CRC_W     16

// Marker bits per PHY word
`define LPIF_MRK_W     4

// 91-bit flit + 1 strobe + 4 markers
`define LPIF_PHY_W     96

// Delay and strobe period values
`define LPIF_DLY_W     16

`endif

/* lpif_link_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types for the link-layer slave
// Flit layout and the PHY word bit positions
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lpif_link_params.svh"

package lpif_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // Flit

  // Valid sits in the top bit, state in the bottom nibble
  typedef struct packed {
    logic                       valid;
    logic                       crc_valid;
    logic [`LPIF_CRC_W-1:0]     crc;
    logic                       dvalid;
    logic [`LPIF_DATA_W-1:0]    data;
    logic [`LPIF_PROTID_W-1:0]  protid;
    logic [`LPIF_STATE_W-1:0]   state;
  } lpif_flit_t;

  // Marker vector, one bit per marker lane
  typedef logic [`LPIF_MRK_W-1:0] lpif_mrk_t;

  //////////////////////////////////////////////////////////////////////
  // PHY word layout

  // Flit occupies bits 0 to 90
  localparam int LPIF_FLIT_W  = $bits(lpif_flit_t);
  // Strobe right above the flit, bit 91
  localparam int LPIF_STB_POS = LPIF_FLIT_W;
  // Markers in bits 92 to 95
  localparam int LPIF_MRK_POS = LPIF_STB_POS + 1;

endpackage

`default_nettype wire

/* lpif_link_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the link-layer slave, with tx_phy looped back to rx_phy
// Covers reset, online release, the flit table, the counters and a link drop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lpif_link_params.svh"

module lpif_link_tb;
  import lpif_link_pkg::*;

  // Sync configuration under test
  localparam int DLY_X  = 5;
  localparam int DLY_Y  = 8;
  localparam int DLY_Z  = 3;
  localparam int N_ROWS = 16;
  localparam logic [`LPIF_MRK_W-1:0] MRK = 4'hA;
  // Sum of the delays, the table length and a margin
  localparam int TIMEOUT_CYC = DLY_X + DLY_Y + DLY_Z + N_ROWS + 50;

  logic                       clk_wr;
  logic                       rst_n;
  logic                       tx_online;
  logic                       rx_online;
  logic [`LPIF_PHY_W-1:0]     tx_phy;
  logic [`LPIF_PHY_W-1:0]     rx_phy;
  logic [`LPIF_STATE_W-1:0]   ustrm_state;
  logic [`LPIF_PROTID_W-1:0]  ustrm_protid;
  logic [`LPIF_DATA_W-1:0]    ustrm_data;
  logic                       ustrm_dvalid;
  logic [`LPIF_CRC_W-1:0]     ustrm_crc;
  logic                       ustrm_crc_valid;
  logic                       ustrm_valid;
  logic [`LPIF_STATE_W-1:0]   dstrm_state;
  logic [`LPIF_PROTID_W-1:0]  dstrm_protid;
  logic [`LPIF_DATA_W-1:0]    dstrm_data;
  logic                       dstrm_dvalid;
  logic [`LPIF_CRC_W-1:0]     dstrm_crc;
  logic                       dstrm_crc_valid;
  logic                       dstrm_valid;
  logic [31:0]                rx_debug_status;
  logic [31:0]                tx_debug_status;
  logic [`LPIF_MRK_W-1:0]     tx_mrk_userbit;
  logic                       tx_stb_userbit;
  logic [`LPIF_DLY_W-1:0]     delay_x_value;
  logic [`LPIF_DLY_W-1:0]     delay_y_value;
  logic [`LPIF_DLY_W-1:0]     delay_z_value;

  // Stimulus table, each row is also the expected dstrm flit
  lpif_flit_t  tbl [N_ROWS];
  logic [31:0] lcg_state;
  int          tx_edges;
  int          cycle_count;

  lpif_link_top lpif_link_top_inst (.*);

  // External PHY loopback
  assign rx_phy = tx_phy;

  //////////////////////////////////////////////////////////////////////
  // Clock and timeout

  initial clk_wr = 1'b0;
  always #2 clk_wr = ~clk_wr;

  initial cycle_count = 0;
  always @(posedge clk_wr) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TEST FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // Bound checker
  always @(lpif_link_top_inst.lpif_link_chk_inst.assert_fails) begin
    if (lpif_link_top_inst.lpif_link_chk_inst.assert_fails != 0) begin
      $display("An assertion in the bound checker failed");
      $display("TEST FAILED");
      $fatal(1, "Stopping at the first assertion failure");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic compare_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic drive_row(input lpif_flit_t r);
    ustrm_state     = r.state;
    ustrm_protid    = r.protid;
    ustrm_data      = r.data;
    ustrm_dvalid    = r.dvalid;
    ustrm_crc       = r.crc;
    ustrm_crc_valid = r.crc_valid;
    ustrm_valid     = r.valid;
  endtask

  task automatic check_dstrm(input lpif_flit_t r);
    compare_value("dstrm_state", dstrm_state, r.state);
    compare_value("dstrm_protid", dstrm_protid, r.protid);
    compare_value("dstrm_data", dstrm_data, r.data);
    compare_value("dstrm_dvalid", dstrm_dvalid, r.dvalid);
    compare_value("dstrm_crc", dstrm_crc, r.crc);
    compare_value("dstrm_crc_valid", dstrm_crc_valid, r.crc_valid);
    compare_value("dstrm_valid", dstrm_valid, r.valid);
  endtask

  // One clock, then strobe and marker checks while tx_online is held
  task automatic step_clock();
    int w;
    @(negedge clk_wr);
    if (tx_online)
      tx_edges++;
    else
      tx_edges = -1;
    if (tx_online) begin
      // Word index since the first online word
      w = tx_edges - (DLY_X + 1);
      if (w < 0) begin
        compare_value("tx_phy", tx_phy, '0);
      end else begin
        compare_value("tx_phy strobe", tx_phy[LPIF_STB_POS],
                      (DLY_Z == 0) || (w % DLY_Z == 0));
        compare_value("tx_phy marker", tx_phy[LPIF_MRK_POS +: `LPIF_MRK_W], MRK);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    lpif_flit_t  r;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    int          n_valid;
    int          i;
    int          k;

    rst_n          = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = MRK;
    tx_stb_userbit = 1'b1;
    delay_x_value  = DLY_X;
    delay_y_value  = DLY_Y;
    delay_z_value  = DLY_Z;
    drive_row('0);
    tx_edges   = -1;
    lcg_state  = 32'd59727;

    // Random rows, every even row valid
    n_valid = 0;
    for (i = 0; i < N_ROWS; i++) begin
      r1 = lcg_next();
      r2 = lcg_next();
      r3 = lcg_next();
      tbl[i].state     = r1[3:0];
      tbl[i].protid    = r1[7:4];
      tbl[i].dvalid    = r1[8];
      tbl[i].crc_valid = r1[9];
      tbl[i].crc       = r1[31:16];
      tbl[i].data      = {r2, r3};
      tbl[i].valid     = r3[0] | (i % 2 == 0);
      n_valid += tbl[i].valid;
    end

    #1;
    rst_n = 1'b0;
    repeat (5) @(negedge clk_wr);
    rst_n = 1'b1;

    // Idle outputs after reset
    step_clock();
    compare_value("tx_phy", tx_phy, '0);
    check_dstrm('0);
    compare_value("tx_debug_status", tx_debug_status, '0);
    compare_value("rx_debug_status", rx_debug_status, '0);

    // Online release, edge k is the k-th clock after the first high sample
    tx_online = 1'b1;
    rx_online = 1'b1;
    for (k = 0; k <= DLY_Y + 1; k++) begin
      step_clock();
      compare_value("tx_debug_status[19]", tx_debug_status[19], k >= DLY_X);
      compare_value("tx_debug_status[18]", tx_debug_status[18], k >= DLY_Y);
      compare_value("rx_debug_status[19]", rx_debug_status[19], k >= DLY_X);
      compare_value("rx_debug_status[18]", rx_debug_status[18], k >= DLY_Y);
    end

    // Table through the loopback, tx_phy after 2 cycles and dstrm after 4
    for (i = 0; i <= N_ROWS + 4; i++) begin
      step_clock();
      if (i >= 4 && i - 4 < N_ROWS)
        check_dstrm(tbl[i-4]);
      if (i >= 2 && i - 2 < N_ROWS)
        compare_value("tx_phy flit", tx_phy[LPIF_STB_POS-1:0], tbl[i-2]);
      drive_row((i < N_ROWS) ? tbl[i] : lpif_flit_t'('0));
    end

    // Both counters saw every valid row
    compare_value("tx_debug_status", tx_debug_status, {12'h0, 2'b11, 2'b00, 16'(n_valid)});
    compare_value("rx_debug_status", rx_debug_status, {12'h0, 2'b11, 2'b00, 16'(n_valid)});

    // Link drop with a valid flit in flight
    r = tbl[0];
    r.valid = 1'b1;
    drive_row(r);
    step_clock();
    tx_online = 1'b0;
    for (k = 0; k < 6; k++) begin
      step_clock();
      if (k >= 1)
        compare_value("tx_phy", tx_phy, '0);
      if (k == 2)
        compare_value("dstrm_valid", dstrm_valid, 1'b1);
      if (k >= 3)
        compare_value("dstrm_valid", dstrm_valid, 1'b0);
    end

    // Transmit back online, the offered flit reaches dstrm again
    tx_online = 1'b1;
    for (k = 0; k <= DLY_X + 3; k++)
      step_clock();
    check_dstrm(r);

    // Receive drop while flits keep arriving, dstrm goes quiet
    rx_online = 1'b0;
    for (k = 0; k < 4; k++) begin
      step_clock();
      if (k >= 1)
        check_dstrm('0);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* lpif_link_top.sv */
//////////////////////////////////////////////////////////////////////
// Link-layer slave top level, plain ports toward user and PHY
// Wires auto-sync, flit codec and PHY mapper, builds the debug words
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lpif_link_params.svh"

module lpif_link_top (
  input  logic                       clk_wr,
  input  logic                       rst_n,

  // Link control
  input  logic                       tx_online,
  input  logic                       rx_online,

  // PHY interconnect
  output logic [`LPIF_PHY_W-1:0]     tx_phy,
  input  logic [`LPIF_PHY_W-1:0]     rx_phy,

  // Upstream channel
  input  logic [`LPIF_STATE_W-1:0]   ustrm_state,
  input  logic [`LPIF_PROTID_W-1:0]  ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0]    ustrm_data,
  input  logic                       ustrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]     ustrm_crc,
  input  logic                       ustrm_crc_valid,
  input  logic                       ustrm_valid,

  // Downstream channel
  output logic [`LPIF_STATE_W-1:0]   dstrm_state,
  output logic [`LPIF_PROTID_W-1:0]  dstrm_protid,
  output logic [`LPIF_DATA_W-1:0]    dstrm_data,
  output logic                       dstrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]     dstrm_crc,
  output logic                       dstrm_crc_valid,
  output logic                       dstrm_valid,

  // Debug status
  output logic [31:0]                rx_debug_status,
  output logic [31:0]                tx_debug_status,

  // User bits and sync configuration
  input  logic [`LPIF_MRK_W-1:0]     tx_mrk_userbit,
  input  logic                       tx_stb_userbit,
  input  logic [`LPIF_DLY_W-1:0]     delay_x_value,
  input  logic [`LPIF_DLY_W-1:0]     delay_y_value,
  input  logic [`LPIF_DLY_W-1:0]     delay_z_value
);
  import lpif_link_pkg::*;

  lpif_flit_t  tx_flit;
  lpif_flit_t  rx_flit;
  logic [15:0] tx_count;
  logic [15:0] rx_count;

  lpif_sync_if sync_if ();

  //////////////////////////////////////////////////////////////////////
  // Auto sync

  lpif_auto_sync lpif_auto_sync_inst (
    .clk_wr         (clk_wr),
    .rst_wr_n       (rst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .sync           (sync_if.src)
  );

  //////////////////////////////////////////////////////////////////////
  // User side

  lpif_flit_codec lpif_flit_codec_inst (
    .clk_wr          (clk_wr),
    .rst_wr_n        (rst_n),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .tx_count        (tx_count),
    .rx_count        (rx_count),
    .sync            (sync_if.codec)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY side

  lpif_phy_mapper lpif_phy_mapper_inst (
    .clk_wr   (clk_wr),
    .rst_wr_n (rst_n),
    .tx_flit  (tx_flit),
    .rx_flit  (rx_flit),
    .tx_phy   (tx_phy),
    .rx_phy   (rx_phy),
    .sync     (sync_if.map)
  );

  //////////////////////////////////////////////////////////////////////
  // Debug status

  // Bit 19 tx flag, bit 18 rx flag, low half the flit count
  assign tx_debug_status = {12'h0, sync_if.tx_online_dly, sync_if.rx_online_dly,
                            2'b00, tx_count};
  assign rx_debug_status = {12'h0, sync_if.tx_online_dly, sync_if.rx_online_dly,
                            2'b00, rx_count};

endmodule

`default_nettype wire

/* lpif_phy_mapper.sv */
//////////////////////////////////////////////////////////////////////
// PHY word mapper between flits and the 96-bit PHY interface
// Adds strobe and markers on transmit, strips them on receive
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "lpif_link_params.svh"

module lpif_phy_mapper (
  input  logic                       clk_wr,
  input  logic                       rst_wr_n,

  // Flit side
  input  lpif_link_pkg::lpif_flit_t  tx_flit,
  output lpif_link_pkg::lpif_flit_t  rx_flit,

  // PHY side
  output logic [`LPIF_PHY_W-1:0]     tx_phy,
  input  logic [`LPIF_PHY_W-1:0]     rx_phy,

  lpif_sync_if.map                   sync
);
  import lpif_link_pkg::*;

  // Assembled transmit word before the output register
  logic [`LPIF_PHY_W-1:0] tx_word;
  // Flit part of the received word
  lpif_flit_t             rx_word_flit;

  //////////////////////////////////////////////////////////////////////
  // Transmit

  // Layout
  //   [90:0]   flit
  //   [91]     strobe
  //   [95:92]  markers
  always_comb begin
    tx_word                                = '0;
    tx_word[LPIF_STB_POS-1:0]              = tx_flit;
    tx_word[LPIF_STB_POS]                  = sync.stb_userbit;
    tx_word[LPIF_MRK_POS +: `LPIF_MRK_W]   = sync.mrk_userbit;
  end

  // Idle PHY lanes carry zeros until transmit is released
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_phy <= '0;
    end else if (sync.tx_online_dly) begin
      tx_phy <= tx_word;
    end else begin
      tx_phy <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive

  // Strobe and marker bits are alignment aids only
  // Nothing downstream needs them, so only the flit bits are kept
  assign rx_word_flit = rx_phy[LPIF_STB_POS-1:0];

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      rx_flit <= '0;
    end else if (sync.rx_online_dly) begin
      rx_flit <= rx_word_flit;
    end else begin
      // Drop whatever the PHY shows before receive is released
      rx_flit <= '0;
    end
  end

endmodule

`default_nettype wire

/* lpif_sync_if.sv */
//////////////////////////////////////////////////////////////////////
// Auto-sync outputs shared by the codec and the PHY mapper
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface lpif_sync_if;
  import lpif_link_pkg::*;

  // Online flags, released after the programmed delays
  logic       tx_online_dly;
  logic       rx_online_dly;

  // Persistent marker for the PHY word
  lpif_mrk_t  mrk_userbit;

  // Periodic strobe for the PHY word
  logic       stb_userbit;

  // Auto-sync side
  modport src (
    output tx_online_dly,
    output rx_online_dly,
    output mrk_userbit,
    output stb_userbit
  );

  // PHY mapper side, needs the user bits too
  modport map (
    input  tx_online_dly,
    input  rx_online_dly,
    input  mrk_userbit,
    input  stb_userbit
  );

  // Codec side, flags only
  modport codec (
    input  tx_online_dly,
    input  rx_online_dly
  );

endinterface

`default_nettype wire
